/* files.f */
verilog/tcb_pkg.sv
verilog/tcb_req_reg.sv
verilog/tcb_logsize2byteena.sv
verilog/tcb_mem.sv
verilog/tcb_top.sv
sim/tcb_tb.sv

/* run.sh */
#!/bin/sh
# build the TCB testbench with Verilator and run it from the project root
# exit status is zero only when the simulation ends without a $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps \
  --top-module tcb_tb -f files.f -Mdir obj_dir -o tcb_sim &&
./obj_dir/tcb_sim ||
{ echo "build or simulation ended with an error"; exit 1; }

/* sim/tcb_golden.mem */
// columns: ctl wdt rdt sts, ctl nibbles = mode wen ndn siz adr[15:0]
// mode 0 random gap, 1 no gap, f end marker; ndn 1 is big endian
// little-endian full words
01020000 03020100 00000000 0
01020004 07060504 00000000 0
01020008 0b0a0908 00000000 0
0102000c 0f0e0d0c 00000000 0
// bytes at offsets 0..3, junk above size
01000000 ffffff10 00000000 0
01000005 eeeeee15 00000000 0
0100000a dddddd1a 00000000 0
0100000f cccccc1f 00000000 0
// halfwords at offsets 2, 3 (wraps), 0, 1
01010002 bbbb2322 00000000 0
01010007 aaaa2726 00000000 0
01010008 99992928 00000000 0
0101000d 88882e2d 00000000 0
// words at offsets 1..3 rotate within the word
01020011 44332211 00000000 0
01020016 88776655 00000000 0
0102001b ccbbaa99 00000000 0
// full-word reads of the merged contents
00020000 00000000 23220110 0
00020004 00000000 26061527 0
00020008 00000000 0b1a2928 0
0002000c 00000000 1f2e2d0c 0
00020010 00000000 33221144 0
00020014 00000000 66558877 0
00020018 00000000 99ccbbaa 0
// sized reads, little then big endian
0000000d 00000000 0000002d 0
00010002 00000000 00002322 0
00010007 00000000 00002726 0
0010000a 00000000 0000001a 0
00110008 00000000 00002829 0
0011000b 00000000 00000b28 0
00120010 00000000 44112233 0
00020016 00000000 88776655 0
00120019 00000000 bbcc99aa 0
// big-endian writes, little-endian reads
01120020 11223344 00000000 0
00020020 00000000 44332211 0
01020024 5a5a5a5a 00000000 0
01110026 0000c0c1 00000000 0
00020024 00000000 c1c05a5a 0
00010026 00000000 0000c1c0 0
// out of range, then the aliased word is unchanged
01020120 deadbeef 00000000 1
00020100 00000000 00000000 1
0010fffd 00000000 00000000 1
00020020 00000000 44332211 0
// back-to-back burst
11020030 76543210 00000000 0
11020034 fedcba98 00000000 0
10020030 00000000 76543210 0
10020034 00000000 fedcba98 0
10110032 00000000 00005476 0
10000037 00000000 000000fe 0
11000031 000000aa 00000000 0
10020030 00000000 7654aa10 0
f0000000 00000000 00000000 0

/* sim/tcb_tb.sv */
// TCB subsystem testbench
// replays golden records through the top level and checks data, status,
// latency and order of every response

module tcb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // clock period in ns
  localparam int CLK_PER = 40;
  localparam int RST_CYC = 8;
  // cycles from driving an accepted request to seeing its response
  localparam int RSP_LAT = 2;
  // golden array depth in records of four words
  localparam int MAX_REC = 64;

  logic                        clk;
  logic                        rst_n;
  logic                        req_vld;
  logic                        req_rdy;
  logic                        req_wen;
  tcb_pkg::tcb_endian_t        req_ndn;
  logic [tcb_pkg::BUS_MAX-1:0] req_siz;
  logic [tcb_pkg::ADR_WID-1:0] req_adr;
  tcb_pkg::tcb_data_t          req_wdt;
  logic                        rsp_vld;
  tcb_pkg::tcb_data_t          rsp_rdt;
  logic                        rsp_sts;

  // four words per record for control, write data, read data and status
  logic [31:0] gold [0:4*MAX_REC-1];
  int          num_rec = 0;
  integer      seed = 32'h667b_d02a;
  // rising edges since time zero
  int          cyc = 0;
  int          req_cnt = 0;
  int          rsp_cnt = 0;
  // accepted records oldest first with their drive cycle
  int          q_idx [$];
  int          q_cyc [$];

  tcb_top tcb_top_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_rdy (req_rdy),
    .req_wen (req_wen),
    .req_ndn (req_ndn),
    .req_siz (req_siz),
    .req_adr (req_adr),
    .req_wdt (req_wdt),
    .rsp_vld (rsp_vld),
    .rsp_rdt (rsp_rdt),
    .rsp_sts (rsp_sts)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PER/2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic string rec_name(input int idx);
    rec_name = $sformatf("rec %0d", idx);
  endfunction

  task automatic check_data(input string name, input tcb_pkg::tcb_data_t exp,
                            input tcb_pkg::tcb_data_t act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s rdt expected %h actual %h",
                          name, exp.wrd, act.wrd));
    end
  endtask

  task automatic check_sts(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s sts expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_cnt(input string name, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  // drive one record and hold it until the slice takes it
  task automatic send_rec(input int idx);
    logic [31:0] ctl;
    ctl = gold[4*idx];
    @(negedge clk);
    req_vld     = 1'b1;
    req_wen     = ctl[24];
    req_ndn     = tcb_pkg::tcb_endian_t'(ctl[20]);
    req_siz     = ctl[17:16];
    req_adr     = ctl[15:0];
    req_wdt.wrd = gold[4*idx+1];
    while (!req_rdy) begin
      @(negedge clk);
    end
    // handshake on the coming rising edge
    q_idx.push_back(idx);
    q_cyc.push_back(cyc);
    req_cnt++;
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin : main_seq
    int n;
    int gap;
    bit rdy_ok;
    rst_n   = 1'b0;
    req_vld = 1'b0;
    req_wen = 1'b0;
    req_ndn = tcb_pkg::TCB_LITTLE;
    req_siz = '0;
    req_adr = '0;
    req_wdt = '0;
    $readmemh("sim/tcb_golden.mem", gold);
    // records end at a control word with top nibble f
    n = 0;
    while (n < MAX_REC && gold[4*n][31:28] != 4'hf) begin
      n++;
    end
    if (n == 0 || n == MAX_REC) begin
      abort_run("golden file is empty or has no end marker");
    end
    num_rec = n;

    // no response may show up during reset
    repeat (RST_CYC) begin
      @(negedge clk);
      if (rsp_vld !== 1'b0) begin
        abort_run("rsp_vld went high while reset was asserted");
      end
    end
    rst_n  = 1'b1;
    rdy_ok = 1'b0;
    for (int i = 0; i < 2 && !rdy_ok; i++) begin
      @(negedge clk);
      rdy_ok = req_rdy;
    end
    if (!rdy_ok) begin
      abort_run("req_rdy stayed low for 2 cycles after reset release");
    end

    for (int i = 0; i < num_rec; i++) begin
      // mode 1 means issue right behind the previous record
      if (gold[4*i][31:28] == 4'h1) begin
        gap = 0;
      end else begin
        gap = int'($unsigned($random(seed)) % 32'd3);
      end
      if (gap != 0) begin
        @(negedge clk);
        req_vld = 1'b0;
        repeat (gap - 1) @(negedge clk);
      end
      send_rec(i);
    end
    @(negedge clk);
    req_vld = 1'b0;

    // last response due RSP_LAT cycles after the last handshake
    // then a few quiet cycles to catch stray pulses
    repeat (RSP_LAT + 4) @(negedge clk);
    check_cnt("response count", req_cnt, rsp_cnt);
    $display("=== PASS ===");
    $finish;
  end

  //////////////////////////////
  // response checks
  //////////////////////////////

  initial begin : rsp_monitor
    int                 idx;
    int                 lat;
    tcb_pkg::tcb_data_t exp_rdt;
    forever begin
      @(negedge clk);
      if (rst_n && rsp_vld) begin
        if (q_idx.size() == 0) begin
          abort_run("response pulse arrived with no request outstanding");
        end else begin
          idx = q_idx.pop_front();
          lat = cyc - q_cyc.pop_front();
          exp_rdt.wrd = gold[4*idx+2];
          check_data(rec_name(idx), exp_rdt, rsp_rdt);
          check_sts(rec_name(idx), gold[4*idx+3][0], rsp_sts);
          check_cnt({rec_name(idx), " latency"}, RSP_LAT, lat);
          rsp_cnt++;
        end
      end
    end
  end

  // bound on run length scaled by record count
  initial begin : watchdog
    wait (num_rec != 0);
    #((num_rec * 4 + 50) * CLK_PER);
    abort_run($sformatf("timeout, test not done after %0d cycles", num_rec * 4 + 50));
  end

endmodule : tcb_tb

/* verilog/tcb_top.sv */
// TCB subsystem top
// register slice, log-size converter and byte-enabled memory in a chain

module tcb_top (
  input  logic                               clk,
  input  logic                               rst_n,
  // manager request
  input  logic                               req_vld,
  output logic                               req_rdy,
  input  logic                               req_wen,
  input  tcb_pkg::tcb_endian_t               req_ndn,
  input  logic [tcb_pkg::BUS_MAX-1:0]        req_siz,
  input  logic [tcb_pkg::ADR_WID-1:0]        req_adr,
  input  tcb_pkg::tcb_data_t                 req_wdt,
  // manager response
  output logic                               rsp_vld,
  output tcb_pkg::tcb_data_t                 rsp_rdt,
  output logic                               rsp_sts
);

  // slice to converter
  logic                               reg_vld;
  logic                               reg_rdy;
  logic                               reg_wen;
  tcb_pkg::tcb_endian_t               reg_ndn;
  logic [tcb_pkg::BUS_MAX-1:0]        reg_siz;
  logic [tcb_pkg::ADR_WID-1:0]        reg_adr;
  tcb_pkg::tcb_data_t                 reg_wdt;

  // converter to memory
  logic                               mem_vld;
  logic                               mem_rdy;
  logic                               mem_wen;
  logic [tcb_pkg::ADR_WID-1:0]        mem_adr;
  logic [tcb_pkg::BUS_BEN-1:0]        mem_ben;
  tcb_pkg::tcb_data_t                 mem_wdt;
  logic                               mem_rsp_vld;
  tcb_pkg::tcb_data_t                 mem_rsp_rdt;
  logic                               mem_rsp_sts;

  //////////////////////////////
  // request slice
  //////////////////////////////

  tcb_req_reg tcb_req_reg_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .sub_vld (req_vld),
    .sub_rdy (req_rdy),
    .sub_wen (req_wen),
    .sub_ndn (req_ndn),
    .sub_siz (req_siz),
    .sub_adr (req_adr),
    .sub_wdt (req_wdt),
    .man_vld (reg_vld),
    .man_rdy (reg_rdy),
    .man_wen (reg_wen),
    .man_ndn (reg_ndn),
    .man_siz (reg_siz),
    .man_adr (reg_adr),
    .man_wdt (reg_wdt)
  );

  //////////////////////////////
  // size conversion
  //////////////////////////////

  tcb_logsize2byteena tcb_logsize2byteena_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .sub_vld     (reg_vld),
    .sub_rdy     (reg_rdy),
    .sub_wen     (reg_wen),
    .sub_ndn     (reg_ndn),
    .sub_siz     (reg_siz),
    .sub_adr     (reg_adr),
    .sub_wdt     (reg_wdt),
    .sub_rsp_vld (rsp_vld),
    .sub_rsp_rdt (rsp_rdt),
    .sub_rsp_sts (rsp_sts),
    .man_vld     (mem_vld),
    .man_rdy     (mem_rdy),
    .man_wen     (mem_wen),
    .man_adr     (mem_adr),
    .man_ben     (mem_ben),
    .man_wdt     (mem_wdt),
    .man_rsp_vld (mem_rsp_vld),
    .man_rsp_rdt (mem_rsp_rdt),
    .man_rsp_sts (mem_rsp_sts)
  );

  //////////////////////////////
  // memory
  //////////////////////////////

  tcb_mem tcb_mem_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (mem_vld),
    .rdy     (mem_rdy),
    .wen     (mem_wen),
    .adr     (mem_adr),
    .ben     (mem_ben),
    .wdt     (mem_wdt),
    .rsp_vld (mem_rsp_vld),
    .rsp_rdt (mem_rsp_rdt),
    .rsp_sts (mem_rsp_sts)
  );

endmodule : tcb_top

/* verilog/tcb_mem.sv */
// TCB byte-enabled memory subordinate
// word array with lane writes, read data one cycle after handshake,
// error status for addresses past the backed range

module tcb_mem (
  input  logic                               clk,
  input  logic                               rst_n,
  // request
  input  logic                               vld,
  output logic                               rdy,
  input  logic                               wen,
  input  logic [tcb_pkg::ADR_WID-1:0]        adr,
  input  logic [tcb_pkg::BUS_BEN-1:0]        ben,
  input  tcb_pkg::tcb_data_t                 wdt,
  // response
  output logic                               rsp_vld,
  output tcb_pkg::tcb_data_t                 rsp_rdt,
  output logic                               rsp_sts
);

  // storage, one entry per word
  tcb_pkg::tcb_data_t mem [tcb_pkg::MEM_BYTES/tcb_pkg::BUS_BEN];

  // word index, address out of range, handshake
  logic [$clog2(tcb_pkg::MEM_BYTES)-1:$clog2(tcb_pkg::BUS_BEN)] idx;
  logic                                                         oor;
  logic                                                         hsk;

  // always ready once out of reset
  assign rdy = rst_n;
  assign hsk = vld & rdy;

  assign idx = adr[$clog2(tcb_pkg::MEM_BYTES)-1:$clog2(tcb_pkg::BUS_BEN)];
  assign oor = (32'(adr) >= tcb_pkg::MEM_BYTES);

  //////////////////////////////
  // write
  //////////////////////////////

  // enabled lanes only, dropped when out of range
  always_ff @(posedge clk) begin
    if (hsk && wen && !oor) begin
      for (int unsigned i = 0; i < tcb_pkg::BUS_BEN; i++) begin
        if (ben[i]) begin
          mem[idx].byt[i] <= wdt.byt[i];
        end
      end
    end
  end

  //////////////////////////////
  // response
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= hsk;
    end
  end

  // whole word, old contents on a write
  always_ff @(posedge clk) begin
    if (hsk) begin
      rsp_sts <= oor;
      rsp_rdt <= oor ? '0 : mem[idx];
    end
  end

endmodule : tcb_mem

/* verilog/tcb_logsize2byteena.sv */
// TCB log-size to byte-enable converter
// maps size, offset and endianness onto lane enables and rotates write data,
// realigns read data to the right using a delayed copy of the request

module tcb_logsize2byteena (
  input  logic                               clk,
  input  logic                               rst_n,
  // subordinate side, log-size requests
  input  logic                               sub_vld,
  output logic                               sub_rdy,
  input  logic                               sub_wen,
  input  tcb_pkg::tcb_endian_t               sub_ndn,
  input  logic [tcb_pkg::BUS_MAX-1:0]        sub_siz,
  input  logic [tcb_pkg::ADR_WID-1:0]        sub_adr,
  input  tcb_pkg::tcb_data_t                 sub_wdt,
  output logic                               sub_rsp_vld,
  output tcb_pkg::tcb_data_t                 sub_rsp_rdt,
  output logic                               sub_rsp_sts,
  // manager side, byte-enable requests
  output logic                               man_vld,
  input  logic                               man_rdy,
  output logic                               man_wen,
  output logic [tcb_pkg::ADR_WID-1:0]        man_adr,
  output logic [tcb_pkg::BUS_BEN-1:0]        man_ben,
  output tcb_pkg::tcb_data_t                 man_wdt,
  input  logic                               man_rsp_vld,
  input  tcb_pkg::tcb_data_t                 man_rsp_rdt,
  input  logic                               man_rsp_sts
);

  // lane carrying data byte idx
  // little: off + idx, big: off + (2^siz - 1) - idx, both wrap in the word
  function automatic logic [tcb_pkg::BUS_MAX-1:0] lane_sel (
    input tcb_pkg::tcb_endian_t          ndn,
    input logic [tcb_pkg::BUS_MAX-1:0]   off,
    input logic [tcb_pkg::BUS_MAX-1:0]   siz,
    input logic [tcb_pkg::BUS_MAX-1:0]   idx
  );
    logic [31:0]                 msk;
    logic [tcb_pkg::BUS_MAX-1:0] top;
    msk = (32'd1 << siz) - 32'd1;
    top = msk[tcb_pkg::BUS_MAX-1:0];
    if (ndn == tcb_pkg::TCB_BIG) begin
      lane_sel = off + top - idx;
    end else begin
      lane_sel = off + idx;
    end
  endfunction : lane_sel

  // request offset and memory handshake
  logic [tcb_pkg::BUS_MAX-1:0] req_off;
  logic                        man_hsk;

  // delay line, one stage per cycle of memory latency
  logic [tcb_pkg::HSK_DLY-1:0]                       dly_vld;
  logic [tcb_pkg::HSK_DLY-1:0]                       dly_wen;
  logic [tcb_pkg::HSK_DLY-1:0][tcb_pkg::BUS_MAX-1:0] dly_off;
  logic [tcb_pkg::HSK_DLY-1:0][tcb_pkg::BUS_MAX-1:0] dly_siz;
  tcb_pkg::tcb_endian_t                              dly_ndn [tcb_pkg::HSK_DLY];

  // last stage, lines up with read data
  logic                        rsp_rd;
  logic [tcb_pkg::BUS_MAX-1:0] rsp_off;
  logic [tcb_pkg::BUS_MAX-1:0] rsp_siz;
  tcb_pkg::tcb_endian_t        rsp_ndn;

  //////////////////////////////
  // request path
  //////////////////////////////

  // handshake and address unchanged
  assign man_vld = sub_vld;
  assign sub_rdy = man_rdy;
  assign man_wen = sub_wen;
  assign man_adr = sub_adr;

  assign req_off = sub_adr[tcb_pkg::BUS_MAX-1:0];
  assign man_hsk = man_vld & man_rdy;

  // scatter data bytes onto lanes, unused lanes stay zero
  always_comb begin
    man_ben = '0;
    man_wdt = '0;
    for (int unsigned k = 0; k < tcb_pkg::BUS_BEN; k++) begin
      if (k < (32'd1 << sub_siz)) begin
        man_ben[lane_sel(sub_ndn, req_off, sub_siz, k[tcb_pkg::BUS_MAX-1:0])] = 1'b1;
        man_wdt.byt[lane_sel(sub_ndn, req_off, sub_siz, k[tcb_pkg::BUS_MAX-1:0])] =
          sub_wdt.byt[k];
      end
    end
  end

  //////////////////////////////
  // delay line
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dly_vld <= '0;
    end else begin
      dly_vld[0] <= man_hsk;
      for (int unsigned i = 1; i < tcb_pkg::HSK_DLY; i++) begin
        dly_vld[i] <= dly_vld[i-1];
      end
    end
  end

  // first stage loads on handshake, later stages just shift
  always_ff @(posedge clk) begin
    if (man_hsk) begin
      dly_wen[0] <= sub_wen;
      dly_off[0] <= req_off;
      dly_siz[0] <= sub_siz;
      dly_ndn[0] <= sub_ndn;
    end
    for (int unsigned i = 1; i < tcb_pkg::HSK_DLY; i++) begin
      dly_wen[i] <= dly_wen[i-1];
      dly_off[i] <= dly_off[i-1];
      dly_siz[i] <= dly_siz[i-1];
      dly_ndn[i] <= dly_ndn[i-1];
    end
  end

  //////////////////////////////
  // response path
  //////////////////////////////

  // only reads carry data back
  assign rsp_rd  = dly_vld[tcb_pkg::HSK_DLY-1] & ~dly_wen[tcb_pkg::HSK_DLY-1];
  assign rsp_off = dly_off[tcb_pkg::HSK_DLY-1];
  assign rsp_siz = dly_siz[tcb_pkg::HSK_DLY-1];
  assign rsp_ndn = dly_ndn[tcb_pkg::HSK_DLY-1];

  // gather lanes back into right-aligned bytes, zero above size
  always_comb begin
    sub_rsp_rdt = '0;
    if (rsp_rd) begin
      for (int unsigned k = 0; k < tcb_pkg::BUS_BEN; k++) begin
        if (k < (32'd1 << rsp_siz)) begin
          sub_rsp_rdt.byt[k] =
            man_rsp_rdt.byt[lane_sel(rsp_ndn, rsp_off, rsp_siz, k[tcb_pkg::BUS_MAX-1:0])];
        end
      end
    end
  end

  // status and pulse pass through
  assign sub_rsp_vld = man_rsp_vld;
  assign sub_rsp_sts = man_rsp_sts;

endmodule : tcb_logsize2byteena

/* verilog/tcb_req_reg.sv */
// TCB request register slice
// one entry, loads on input handshake and drains on output handshake,
// cuts the combinational path from manager to memory

module tcb_req_reg (
  input  logic                               clk,
  input  logic                               rst_n,
  // subordinate side, manager connects here
  input  logic                               sub_vld,
  output logic                               sub_rdy,
  input  logic                               sub_wen,
  input  tcb_pkg::tcb_endian_t               sub_ndn,
  input  logic [tcb_pkg::BUS_MAX-1:0]        sub_siz,
  input  logic [tcb_pkg::ADR_WID-1:0]        sub_adr,
  input  tcb_pkg::tcb_data_t                 sub_wdt,
  // manager side, toward the converter
  output logic                               man_vld,
  input  logic                               man_rdy,
  output logic                               man_wen,
  output tcb_pkg::tcb_endian_t               man_ndn,
  output logic [tcb_pkg::BUS_MAX-1:0]        man_siz,
  output logic [tcb_pkg::ADR_WID-1:0]        man_adr,
  output tcb_pkg::tcb_data_t                 man_wdt
);

  // set one cycle after reset release
  logic ena;
  // handshakes on both sides
  logic hsk_in;
  logic hsk_out;

  // free slot, or slot being drained this cycle
  assign sub_rdy = ena & (~man_vld | man_rdy);

  assign hsk_in  = sub_vld & sub_rdy;
  assign hsk_out = man_vld & man_rdy;

  //////////////////////////////
  // control
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ena     <= 1'b0;
      man_vld <= 1'b0;
    end else begin
      ena <= 1'b1;
      // load wins over drain, keeps one request per cycle
      if (hsk_in) begin
        man_vld <= 1'b1;
      end else if (hsk_out) begin
        man_vld <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // payload
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (hsk_in) begin
      man_wen <= sub_wen;
      man_ndn <= sub_ndn;
      man_siz <= sub_siz;
      man_adr <= sub_adr;
      man_wdt <= sub_wdt;
    end
  end

endmodule : tcb_req_reg

/* verilog/tcb_pkg.sv */
// TCB package
// bus sizes, memory depth, response delay and the shared data types
// used by the slice, the log-size converter and the memory

package tcb_pkg;

  //////////////////////////////
  // bus geometry
  //////////////////////////////

  // byte lanes in a data word
  localparam int unsigned BUS_BEN = 4;
  // offset and size field width, log2 of lanes
  localparam int unsigned BUS_MAX = 2;
  // address bits
  localparam int unsigned ADR_WID = 16;
  // data bits
  localparam int unsigned DAT_WID = 32;

  //////////////////////////////
  // subordinate
  //////////////////////////////

  // bytes backed by the memory, anything above is out of range
  localparam int unsigned MEM_BYTES = 256;
  // handshake to read data latency
  localparam int unsigned HSK_DLY = 1;

  //////////////////////////////
  // types
  //////////////////////////////

  // data word, seen as a whole or as byte lanes
  typedef union packed {
    logic [DAT_WID-1:0]        wrd;
    logic [BUS_BEN-1:0][7:0]   byt;
  } tcb_data_t;

  // per request byte order
  typedef enum logic {
    TCB_LITTLE = 1'b0,
    TCB_BIG    = 1'b1
  } tcb_endian_t;

endpackage : tcb_pkg
